//--- all.f
src/rvPkg.sv
src/rvDecoder.sv
src/rvRegFile.sv
src/rvImmGen.sv
src/rvAlu.sv
src/rvPcUnit.sv
src/rvCore.sv
tests/rvClockGen.sv
tests/rvCore_sva.sv
tests/rvCoreTb.sv

//--- src/rvAlu.sv
module rvAlu (
    input  rvPkg::wordT  srcA,
    input  rvPkg::wordT  srcB,
    input  rvPkg::aluOpT aluOp,
    output rvPkg::wordT  result,
    output logic         zero,
    output logic         negative,
    output logic         carry,
    output logic         overflow
);
    import rvPkg::*;

    logic       isSub;      // adder in subtract mode
    logic       isAddSub;   // flags valid
    logic       carryOut;
    logic       ovf;
    logic [4:0] shamt;
    wordT       bOperand;
    wordT       sum;

    ////////////////////
    // shared adder
    // slt and sltu compare through a - b as well
    assign isSub    = (aluOp == aluSub) || (aluOp == aluSlt) || (aluOp == aluSltu);
    assign isAddSub = (aluOp == aluAdd) || (aluOp == aluSub);

    assign bOperand = isSub ? ~srcB : srcB;   // two's complement with carry-in
    assign {carryOut, sum} = {1'b0, srcA} + {1'b0, bOperand} + {{wordWidth{1'b0}}, isSub};

    // signed overflow, operands alike in sign but sum differs
    assign ovf = (srcA[wordWidth-1] == bOperand[wordWidth-1]) &&
                 (sum[wordWidth-1] != srcA[wordWidth-1]);

    assign shamt = srcB[4:0];   // rv32 shifts use 5 bits

    ////////////////////
    // result select
    always_comb begin
        case (aluOp)
            aluAdd,
            aluSub:  result = sum;
            aluAnd:  result = srcA & srcB;
            aluOr:   result = srcA | srcB;
            aluXor:  result = srcA ^ srcB;
            aluSlt:  result = {{(wordWidth-1){1'b0}}, sum[wordWidth-1] ^ ovf};
            aluSltu: result = {{(wordWidth-1){1'b0}}, ~carryOut};   // borrow means a < b
            aluSll:  result = srcA << shamt;
            aluSrl:  result = srcA >> shamt;
            aluSra:  result = $signed(srcA) >>> shamt;
            default: result = '0;
        endcase
    end

    // branch flags, only meaningful for add/sub
    assign zero     = isAddSub & (sum == '0);
    assign negative = isAddSub & sum[wordWidth-1];
    assign carry    = isAddSub & carryOut;
    assign overflow = isAddSub & ovf;

endmodule

//--- src/rvCore.sv
module rvCore (
    input  logic        clk,
    input  logic        rst,
    input  rvPkg::wordT imemData,
    output rvPkg::wordT imemAddr,
    input  rvPkg::wordT dmemReadData,
    output logic        dmemWrite,
    output rvPkg::wordT dmemAddr,
    output rvPkg::wordT dmemWriteData
);
    import rvPkg::*;

    // control
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       jump;
    logic       jalrSel;
    logic       srcBImm;
    resultSrcT  resultSrc;
    immFormatT  immFormat;
    srcASelT    srcASel;
    aluOpT      aluOp;
    branchCondT brCond;

    // datapath
    wordT pc;
    wordT pcPlus4;
    wordT immExt;
    wordT rd1;
    wordT rd2;
    wordT srcA;
    wordT srcB;
    wordT aluResult;
    wordT result;
    logic zero;
    logic negative;
    logic carry;
    logic overflow;

    assign brCond = branchCondT'(imemData[14:12]);

    ////////////////////
    // units
    rvDecoder decoder (
        .instr     (imemData),
        .regWrite  (regWrite),
        .memWrite  (memWrite),
        .branch    (branch),
        .jump      (jump),
        .jalrSel   (jalrSel),
        .srcBImm   (srcBImm),
        .resultSrc (resultSrc),
        .immFormat (immFormat),
        .srcASel   (srcASel),
        .aluOp     (aluOp)
    );

    rvRegFile regFile (
        .clk (clk),
        .rst (rst),
        .we  (regWrite),
        .ra1 (imemData[19:15]),   // rs1
        .ra2 (imemData[24:20]),   // rs2
        .wa  (imemData[11:7]),    // rd
        .wd  (result),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    rvImmGen immGen (
        .instr     (imemData),
        .immFormat (immFormat),
        .immExt    (immExt)
    );

    // operand muxes
    always_comb begin
        case (srcASel)
            srcAPc:   srcA = pc;
            srcAZero: srcA = '0;
            default:  srcA = rd1;
        endcase
    end

    assign srcB = srcBImm ? immExt : rd2;

    rvAlu alu (
        .srcA     (srcA),
        .srcB     (srcB),
        .aluOp    (aluOp),
        .result   (aluResult),
        .zero     (zero),
        .negative (negative),
        .carry    (carry),
        .overflow (overflow)
    );

    rvPcUnit pcUnit (
        .clk      (clk),
        .rst      (rst),
        .branch   (branch),
        .jump     (jump),
        .jalrSel  (jalrSel),
        .funct3   (brCond),
        .zero     (zero),
        .negative (negative),
        .carry    (carry),
        .overflow (overflow),
        .rs1Val   (rd1),
        .immExt   (immExt),
        .pc       (pc),
        .pcPlus4  (pcPlus4)
    );

    ////////////////////
    // writeback and memory ports
    always_comb begin
        case (resultSrc)
            resMem:     result = dmemReadData;
            resPcPlus4: result = pcPlus4;   // jal/jalr link
            default:    result = aluResult;
        endcase
    end

    assign imemAddr      = pc;
    assign dmemAddr      = aluResult;          // rs1 + offset
    assign dmemWriteData = rd2;
    assign dmemWrite     = memWrite & ~rst;    // no store strobe while in reset

endmodule

//--- src/rvDecoder.sv
module rvDecoder (
    input  rvPkg::wordT      instr,
    output logic             regWrite,
    output logic             memWrite,
    output logic             branch,
    output logic             jump,
    output logic             jalrSel,
    output logic             srcBImm,
    output rvPkg::resultSrcT resultSrc,
    output rvPkg::immFormatT immFormat,
    output rvPkg::srcASelT   srcASel,
    output rvPkg::aluOpT     aluOp
);
    import rvPkg::*;

    opcodeT     opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    logic       useFunct;   // alu op taken from funct3
    logic       rTypeSub;

    assign opcode   = opcodeT'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    ////////////////////
    // main decoder
    always_comb begin
        regWrite  = 1'b0;   // unknown opcode writes nothing
        memWrite  = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        jalrSel   = 1'b0;
        srcBImm   = 1'b0;
        useFunct  = 1'b0;
        resultSrc = resAlu;
        immFormat = immI;
        srcASel   = srcAReg;
        case (opcode)
            opLoad: begin
                regWrite  = 1'b1;
                srcBImm   = 1'b1;   // rs1 + offset
                resultSrc = resMem;
            end
            opStore: begin
                memWrite  = 1'b1;
                srcBImm   = 1'b1;
                immFormat = immS;
            end
            opOp: begin
                regWrite = 1'b1;
                useFunct = 1'b1;
            end
            opOpImm: begin
                regWrite = 1'b1;
                srcBImm  = 1'b1;
                useFunct = 1'b1;
            end
            opBranch: begin
                branch    = 1'b1;   // compare rs1 - rs2
                immFormat = immB;
            end
            opJal: begin
                regWrite  = 1'b1;
                jump      = 1'b1;
                immFormat = immJ;
                resultSrc = resPcPlus4;   // link
            end
            opJalr: begin
                regWrite  = 1'b1;
                jump      = 1'b1;
                jalrSel   = 1'b1;   // target from rs1
                resultSrc = resPcPlus4;
            end
            opAuipc: begin
                regWrite  = 1'b1;
                srcBImm   = 1'b1;
                immFormat = immU;
                srcASel   = srcAPc;
            end
            opLui: begin
                regWrite  = 1'b1;
                srcBImm   = 1'b1;
                immFormat = immU;
                srcASel   = srcAZero;   // 0 + upper imm
            end
            default: ;
        endcase
    end

    ////////////////////
    // alu decoder
    assign rTypeSub = funct7b5 & (opcode == opOp);   // addi never subtracts

    always_comb begin
        if (branch) begin
            aluOp = aluSub;   // flags for every branch come from rs1 - rs2
        end else if (!useFunct) begin
            aluOp = aluAdd;   // address and upper-imm arithmetic
        end else begin
            case (funct3)
                3'b000:  aluOp = rTypeSub ? aluSub : aluAdd;
                3'b001:  aluOp = aluSll;
                3'b010:  aluOp = aluSlt;
                3'b011:  aluOp = aluSltu;
                3'b100:  aluOp = aluXor;
                3'b101:  aluOp = funct7b5 ? aluSra : aluSrl;   // srai shares bit 30
                3'b110:  aluOp = aluOr;
                default: aluOp = aluAnd;
            endcase
        end
    end

endmodule

//--- src/rvImmGen.sv
module rvImmGen (
    input  rvPkg::wordT      instr,
    input  rvPkg::immFormatT immFormat,
    output rvPkg::wordT      immExt
);
    import rvPkg::*;

    logic signBit;

    assign signBit = instr[31];   // all formats take the sign from bit 31

    always_comb begin
        case (immFormat)
            immI:    immExt = {{20{signBit}}, instr[31:20]};
            immS:    immExt = {{20{signBit}}, instr[31:25], instr[11:7]};
            // b and j offsets are halfword aligned
            immB:    immExt = {{20{signBit}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            immJ:    immExt = {{12{signBit}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            immU:    immExt = {instr[31:12], 12'h000};   // upper 20 over zeros
            default: immExt = '0;
        endcase
    end

endmodule

//--- src/rvPcUnit.sv
module rvPcUnit (
    input  logic              clk,
    input  logic              rst,
    input  logic              branch,
    input  logic              jump,
    input  logic              jalrSel,
    input  rvPkg::branchCondT funct3,
    input  logic              zero,
    input  logic              negative,
    input  logic              carry,
    input  logic              overflow,
    input  rvPkg::wordT       rs1Val,
    input  rvPkg::wordT       immExt,
    output rvPkg::wordT       pc,
    output rvPkg::wordT       pcPlus4
);
    import rvPkg::*;

    logic condMet;
    logic taken;
    wordT targetBase;
    wordT targetSum;
    wordT target;
    wordT pcNext;

    ////////////////////
    // branch condition from rs1 - rs2 flags
    always_comb begin
        case (funct3)
            brEq:    condMet = zero;
            brNe:    condMet = ~zero;
            brLt:    condMet = negative ^ overflow;
            brGe:    condMet = ~(negative ^ overflow);
            brLtu:   condMet = ~carry;   // borrow
            brGeu:   condMet = carry;
            default: condMet = 1'b0;     // funct3 2 and 3 are not branches
        endcase
    end

    assign taken = branch & condMet;

    // target adder
    assign targetBase = jalrSel ? rs1Val : pc;
    assign targetSum  = targetBase + immExt;
    assign target     = jalrSel ? {targetSum[wordWidth-1:1], 1'b0} : targetSum;   // jalr drops bit 0

    assign pcPlus4 = pc + pcStep;
    assign pcNext  = (taken | jump) ? target : pcPlus4;

    ////////////////////
    // program counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= resetPc;
        end else begin
            pc <= pcNext;   // one instruction per cycle
        end
    end

endmodule

//--- src/rvPkg.sv
package rvPkg;

    ////////////////////
    // widths and sizes
    localparam int unsigned wordWidth    = 32;
    localparam int unsigned regAddrWidth = 5;
    localparam int unsigned regCount     = 32;   // x0..x31

    typedef logic [wordWidth-1:0]    wordT;      // data, address, instruction
    typedef logic [regAddrWidth-1:0] regAddrT;

    localparam wordT resetPc = 32'h0000_0000;    // first fetch after reset
    localparam wordT pcStep  = 32'd4;            // one word per instruction

    ////////////////////
    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opOp     = 7'b0110011,   // r-type
        opOpImm  = 7'b0010011,   // i-type arith
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opAuipc  = 7'b0010111,
        opLui    = 7'b0110111
    } opcodeT;

    // alu operations
    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluAnd  = 4'd2,
        aluOr   = 4'd3,
        aluXor  = 4'd4,
        aluSlt  = 4'd5,
        aluSltu = 4'd6,
        aluSll  = 4'd7,
        aluSrl  = 4'd8,
        aluSra  = 4'd9
    } aluOpT;

    typedef enum logic [2:0] {
        immI = 3'd0,
        immS = 3'd1,
        immB = 3'd2,
        immJ = 3'd3,
        immU = 3'd4
    } immFormatT;

    // writeback source
    typedef enum logic [1:0] {
        resAlu     = 2'd0,
        resMem     = 2'd1,
        resPcPlus4 = 2'd2
    } resultSrcT;

    typedef enum logic [1:0] {
        srcAReg  = 2'd0,
        srcAPc   = 2'd1,   // auipc
        srcAZero = 2'd2    // lui
    } srcASelT;

    // branch funct3 encodings
    typedef enum logic [2:0] {
        brEq  = 3'b000,
        brNe  = 3'b001,
        brLt  = 3'b100,
        brGe  = 3'b101,
        brLtu = 3'b110,
        brGeu = 3'b111
    } branchCondT;

endpackage

//--- src/rvRegFile.sv
module rvRegFile (
    input  logic           clk,
    input  logic           rst,
    input  logic           we,
    input  rvPkg::regAddrT ra1,
    input  rvPkg::regAddrT ra2,
    input  rvPkg::regAddrT wa,
    input  rvPkg::wordT    wd,
    output rvPkg::wordT    rd1,
    output rvPkg::wordT    rd2
);
    import rvPkg::*;

    wordT regs [regCount];

    // write port, lands on the rising edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin   // x0 never written
            regs[wa] <= wd;
        end
    end

    ////////////////////
    // read ports, combinational
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

//--- tests/rvClockGen.sv
module rvClockGen #(
    parameter int periodNs    = 8,
    parameter int resetCycles = 16
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // release lands 1 ns after an edge
    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

//--- tests/rvCoreTb.sv
module rvCoreTb;
    timeunit 1ns;
    timeprecision 100ps;
    import rvPkg::*;

    localparam int   clkPeriod   = 8;
    localparam int   resetCycles = 16;
    localparam int   imemWords   = 128;
    localparam int   dmemWords   = 256;
    localparam int   sigCount    = 22;
    localparam wordT sigBase     = 32'h100;
    localparam wordT scratchAddr = 32'h200;   // lw round trip
    localparam wordT trapAddr    = 32'h3F0;
    localparam wordT doneAddr    = 32'h3FC;
    localparam wordT opA         = 32'd1234;
    localparam wordT opB         = 32'hFFFF_FED4;   // -300
    localparam wordT bigNeg      = 32'h8000_0000;
    localparam wordT shiftAmt    = 32'd7;

    logic clk;
    logic rst;
    logic dmemWrite;
    wordT imemData;
    wordT imemAddr;
    wordT dmemReadData;
    wordT dmemAddr;
    wordT dmemWriteData;

    wordT imem [imemWords];
    wordT dmem [dmemWords];
    wordT expSig [sigCount];
    logic sigSeen [sigCount];
    wordT jalPc;      // pc of the jal under test
    wordT linkPc;     // pc of auipc x8, 0 ahead of jalr
    wordT auipcPc;
    int   progLen;
    int   assertErrors;
    int   otherErrors;
    logic programReady;
    logic doneSeen;

    // store classification, read by the checker
    wordT sigSlot;
    logic sigStore;
    logic trapStore;
    wordT sigExpected;

    rvClockGen #(.periodNs(clkPeriod), .resetCycles(resetCycles)) clockGen (
        .clk (clk),
        .rst (rst)
    );

    rvCore uut (
        .clk           (clk),
        .rst           (rst),
        .imemData      (imemData),
        .imemAddr      (imemAddr),
        .dmemReadData  (dmemReadData),
        .dmemWrite     (dmemWrite),
        .dmemAddr      (dmemAddr),
        .dmemWriteData (dmemWriteData)
    );

    bind rvCore rvCoreSva sva (.*);

    ////////////////////
    // memory models
    assign imemData     = imem[imemAddr[8:2]];   // word addressed
    assign dmemReadData = dmem[dmemAddr[9:2]];

    assign sigSlot     = (dmemAddr - sigBase) >> 2;   // wraps huge below sigBase
    assign sigStore    = dmemWrite && (sigSlot < sigCount) && (dmemAddr[1:0] == 2'b00);
    assign trapStore   = dmemWrite && (dmemAddr == trapAddr);
    assign sigExpected = sigStore ? expSig[sigSlot] : '0;

    always @(posedge clk) begin
        if (dmemWrite) begin
            dmem[dmemAddr[9:2]] <= dmemWriteData;
            if (sigStore) sigSeen[sigSlot] <= 1'b1;
            if (dmemAddr == doneAddr) doneSeen <= 1'b1;   // end of program
        end
    end

    ////////////////////
    // instruction encoders
    function automatic wordT encR(input logic [6:0] f7, input logic [2:0] f3,
                                  input logic [4:0] rd, input logic [4:0] rs1,
                                  input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, opOp};
    endfunction

    function automatic wordT encI(input wordT imm, input logic [4:0] rs1,
                                  input logic [2:0] f3, input logic [4:0] rd, input opcodeT op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic wordT encS(input wordT imm, input logic [4:0] rs2, input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};   // sw only
    endfunction

    function automatic wordT encB(input wordT off, input logic [4:0] rs1,
                                  input logic [4:0] rs2, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
    endfunction

    function automatic wordT encJ(input wordT off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
    endfunction

    function automatic wordT encU(input logic [19:0] imm, input logic [4:0] rd, input opcodeT op);
        return {imm, rd, op};
    endfunction

    task automatic emit(input wordT w);
        imem[progLen] = w;
        progLen++;
    endtask

    task automatic storeSig(input int slot, input logic [4:0] rs2);
        emit(encS(sigBase + 4 * slot, rs2, 5'd0));
    endtask

    task automatic aluR(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rs1,
                        input logic [4:0] rs2, input int slot);
        emit(encR(f7, f3, 5'd13, rs1, rs2));   // x13 holds each result
        storeSig(slot, 5'd13);
    endtask

    task automatic emitTrap();
        emit(encS(trapAddr, 5'd1, 5'd0));
    endtask

    ////////////////////
    // program image
    task automatic buildProgram();
        logic [2:0] f3List [6];
        logic [4:0] takenA [6];
        logic [4:0] takenB [6];
        logic [4:0] notA [6];
        logic [4:0] notB [6];
        f3List = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        takenA = '{5'd1, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};
        takenB = '{5'd3, 5'd2, 5'd1, 5'd2, 5'd2, 5'd1};
        notA   = '{5'd1, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1};
        notB   = '{5'd2, 5'd3, 5'd2, 5'd1, 5'd1, 5'd2};
        emit(encS(scratchAddr, 5'd0, 5'd0));   // store sits at resetPc through reset
        emit(encI(opA, 5'd0, 3'b000, 5'd1, opOpImm));
        emit(encI(opB, 5'd0, 3'b000, 5'd2, opOpImm));
        emit(encI(opA, 5'd0, 3'b000, 5'd3, opOpImm));   // equal to x1
        emit(encU(20'h80000, 5'd4, opLui));
        emit(encI(shiftAmt, 5'd0, 3'b000, 5'd5, opOpImm));
        aluR(7'h00, 3'b000, 5'd1, 5'd2, 0);
        aluR(7'h20, 3'b000, 5'd1, 5'd2, 1);
        aluR(7'h00, 3'b111, 5'd1, 5'd2, 2);
        aluR(7'h00, 3'b110, 5'd1, 5'd2, 3);
        aluR(7'h00, 3'b100, 5'd1, 5'd2, 4);
        aluR(7'h00, 3'b010, 5'd2, 5'd1, 5);
        aluR(7'h00, 3'b010, 5'd1, 5'd2, 6);
        aluR(7'h00, 3'b011, 5'd1, 5'd2, 7);
        aluR(7'h00, 3'b011, 5'd2, 5'd1, 8);
        aluR(7'h00, 3'b001, 5'd1, 5'd5, 9);
        aluR(7'h00, 3'b101, 5'd4, 5'd5, 10);
        aluR(7'h20, 3'b101, 5'd4, 5'd5, 11);
        emit(encI(32'h403, 5'd2, 3'b101, 5'd13, opOpImm));   // srai by 3
        storeSig(12, 5'd13);
        emit(encI(32'd100, 5'd2, 3'b000, 5'd13, opOpImm));
        storeSig(13, 5'd13);
        emit(encI(32'hFFFF_FFFF, 5'd1, 3'b100, 5'd13, opOpImm));
        storeSig(14, 5'd13);
        emit(encS(scratchAddr, 5'd1, 5'd0));
        emit(encI(scratchAddr, 5'd0, 3'b010, 5'd6, opLoad));
        storeSig(15, 5'd6);
        jalPc = wordT'(progLen * 4);
        emit(encJ(32'd8, 5'd7));
        emitTrap();
        storeSig(16, 5'd7);
        linkPc = wordT'(progLen * 4);
        emit(encU(20'h00000, 5'd8, opAuipc));
        emit(encI(32'd12, 5'd8, 3'b000, 5'd9, opJalr));   // lands past the trap
        emitTrap();
        storeSig(17, 5'd9);
        storeSig(18, 5'd8);
        auipcPc = wordT'(progLen * 4);
        emit(encU(20'h00012, 5'd10, opAuipc));
        storeSig(19, 5'd10);
        emit(encU(20'hABCDE, 5'd11, opLui));
        storeSig(20, 5'd11);
        emit(encI(32'd5, 5'd1, 3'b000, 5'd0, opOpImm));   // write to x0
        storeSig(21, 5'd0);
        // each condition taken, then not taken
        for (int i = 0; i < 6; i++) begin
            emit(encB(32'd8, takenA[i], takenB[i], f3List[i]));
            emitTrap();
            emit(encB(32'd8, notA[i], notB[i], f3List[i]));
            emit(encJ(32'd8, 5'd0));   // hop over the trap
            emitTrap();
        end
        emit(encS(doneAddr, 5'd1, 5'd0));
        emit(encJ(32'd0, 5'd0));   // spin here
    endtask

    // expected signatures, straight from the instruction rules
    task automatic fillExpected();
        expSig[0]  = opA + opB;
        expSig[1]  = opA - opB;
        expSig[2]  = opA & opB;
        expSig[3]  = opA | opB;
        expSig[4]  = opA ^ opB;
        expSig[5]  = ($signed(opB) < $signed(opA)) ? 32'd1 : 32'd0;
        expSig[6]  = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
        expSig[7]  = (opA < opB) ? 32'd1 : 32'd0;
        expSig[8]  = (opB < opA) ? 32'd1 : 32'd0;
        expSig[9]  = opA << shiftAmt;
        expSig[10] = bigNeg >> shiftAmt;
        expSig[11] = $signed(bigNeg) >>> shiftAmt;
        expSig[12] = $signed(opB) >>> 3;
        expSig[13] = opB + 32'd100;
        expSig[14] = ~opA;
        expSig[15] = opA;
        expSig[16] = jalPc + 32'd4;
        expSig[17] = linkPc + 32'd8;   // jalr sits at linkPc + 4
        expSig[18] = linkPc;
        expSig[19] = auipcPc + 32'h0001_2000;
        expSig[20] = 32'hABCD_E000;
        expSig[21] = 32'd0;
    endtask

    task automatic printCounts();
        $display("closing: %0d assertion errors, %0d other errors, %0d total",
                 assertErrors, otherErrors, assertErrors + otherErrors);
    endtask

    ////////////////////
    // main flow
    initial begin
        progLen      = 0;
        assertErrors = 0;
        otherErrors  = 0;
        programReady = 1'b0;
        doneSeen     = 1'b0;
        for (int i = 0; i < dmemWords; i++) dmem[i] = 32'(i) * 32'h9E37_79B1;
        // addi x0, x0, index
        for (int i = 0; i < imemWords; i++) imem[i] = encI(wordT'(i), 5'd0, 3'b000, 5'd0, opOpImm);
        for (int i = 0; i < sigCount; i++) sigSeen[i] = 1'b0;
        buildProgram();
        fillExpected();
        programReady = 1'b1;
        wait (doneSeen);
        repeat (2) @(posedge clk);
        for (int i = 0; i < sigCount; i++) begin
            if (!sigSeen[i]) begin
                $display("signature slot %0d was never stored", i);
                otherErrors++;
            end
        end
        printCounts();
        if (assertErrors + otherErrors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog, four cycles per program word
    initial begin
        wait (programReady);
        #((resetCycles + progLen * 4) * clkPeriod);
        $display("timeout: the program never stored its done marker");
        otherErrors++;
        printCounts();
        $display("test failed");
        $finish;
    end

endmodule

//--- tests/rvCore_sva.sv
module rvCoreSva (
    input logic        clk,
    input logic        rst,
    input rvPkg::wordT imemData,
    input rvPkg::wordT imemAddr,
    input logic        dmemWrite,
    input rvPkg::wordT dmemAddr,
    input rvPkg::wordT dmemWriteData
);
    timeunit 1ns;
    timeprecision 100ps;
    import rvPkg::*;

    opcodeT opcode;
    logic   isControl;   // may redirect the pc

    assign opcode    = opcodeT'(imemData[6:0]);
    assign isControl = (opcode == opBranch) || (opcode == opJal) || (opcode == opJalr);

    ////////////////////
    // reset state
    resetState: assert property (@(posedge clk) rst |-> (imemAddr == resetPc) && !dmemWrite)
        else begin
            $error("CHECK FAILED at %0t ns: pc off resetPc or store strobe during reset", $time);
            rvCoreTb.assertErrors++;
        end

    ////////////////////
    // store traffic
    sigData: assert property (@(posedge clk) rvCoreTb.sigStore |->
                              dmemWriteData == rvCoreTb.sigExpected)
        else begin
            $error("CHECK FAILED at %0t ns: signature %0h got %0h, expected %0h", $time,
                   dmemAddr, dmemWriteData, rvCoreTb.sigExpected);
            rvCoreTb.assertErrors++;
        end

    // wrong branch path reached
    noTrap: assert property (@(posedge clk) !rvCoreTb.trapStore)
        else begin
            $error("CHECK FAILED at %0t ns: store to trap address from pc %0h", $time, imemAddr);
            rvCoreTb.assertErrors++;
        end

    storeOnly: assert property (@(posedge clk) dmemWrite |-> opcode == opStore)
        else begin
            $error("CHECK FAILED at %0t ns: dmemWrite without a store opcode", $time);
            rvCoreTb.assertErrors++;
        end

    ////////////////////
    // sequential fetch
    seqAdvance: assert property (@(posedge clk) disable iff (rst)
                                 !isControl |=> imemAddr == $past(imemAddr) + pcStep)
        else begin
            $error("CHECK FAILED at %0t ns: pc did not step by 4 after %0h", $time,
                   $past(imemAddr));
            rvCoreTb.assertErrors++;
        end

    fetchKnown: assert property (@(posedge clk) disable iff (rst) !$isunknown(imemAddr))
        else begin
            $error("CHECK FAILED at %0t ns: imemAddr has unknown bits", $time);
            rvCoreTb.assertErrors++;
        end

endmodule
